//--- src.f
+incdir+src
src/periphPkg.sv
src/clockControl.sv
src/periphBus.sv
src/dataMemory.sv
src/stopwatch.sv
src/lfsrGen.sv
src/breakUnit.sv
src/socTop.sv
test/socTop_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0 -Wno-fatal
TOP       = socTop_tb
FILELIST  = src.f
OBJDIR    = obj_dir
PASS_MSG  = TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- test/busCases.txt
// Columns, all hex: op (1 write, 2 read, 3 idle, 0 end), address, byte enable, data, expected
// Idle counts sit in the data column. LFSR reads use the testbench model, so expected is 0
1 10010000 F 11223344 00000000
2 10010000 0 00000000 11223344
1 10010000 1 000000AA 00000000
1 10010000 4 00BB0000 00000000
2 10010000 0 00000000 11BB33AA
1 10010004 F 00000000 00000000
1 10010004 C CAFE0000 00000000
1 10010004 2 00001200 00000000
2 10010004 0 00000000 CAFE1200
2 10010000 0 00000000 11BB33AA
1 100103FC F DEADBEEF 00000000
1 100103FC 8 55000000 00000000
2 100103FC 0 00000000 55ADBEEF
2 10010400 0 00000000 00000000
2 00000000 0 00000000 00000000
3 00000000 0 00000010 00000000
1 FF200518 F 00000001 00000000
2 FF200518 0 00000000 00000000
2 FF200518 0 00000000 00000000
2 FF200518 0 00000000 00000000
2 FF200518 0 00000000 00000000
1 FF200518 F 00000000 00000000
2 FF200518 0 00000000 00000000
2 FF200518 0 00000000 00000000
0 00000000 0 00000000 00000000

//--- test/socTop_tb.sv
// SoC peripheral testbench
// Plays the CPU on the data bus. Runs the bus cases from the
// case file, random memory traffic, the stopwatch, the divided
// CPU tick and both break sources, then prints the test counts.

`timescale 1ns/1ps
`include "periph_macros.svh"

module socTop_tb
    import periphPkg::*;
;

    localparam int CASE_MAX = 64;

    logic       iCLK_50;
    logic       arstN;
    logic [3:0] KEY;
    logic [4:0] SW;
    busAddr_t   pc;
    logic       ebreak;
    logic       readEnable;
    logic       writeEnable;
    byteEn_t    byteEnable;
    busAddr_t   address;
    busData_t   writeData;
    busData_t   readData;
    logic [2:0] ledr;

    busData_t   caseWords [0:5*CASE_MAX-1];  // Five fields per case
    busData_t   lfsrModel;
    integer     seed;
    int         tickCount;
    int         errCount;
    int         testErrBase;
    int         passTests;
    int         failTests;

    socTop dut (
        .iCLK_50     (iCLK_50),
        .arstN       (arstN),
        .KEY         (KEY),
        .SW          (SW),
        .pc          (pc),
        .ebreak      (ebreak),
        .readEnable  (readEnable),
        .writeEnable (writeEnable),
        .byteEnable  (byteEnable),
        .address     (address),
        .writeData   (writeData),
        .readData    (readData),
        .ledr        (ledr)
    );

    always #2 iCLK_50 = ~iCLK_50;

    // Counts cpuTick through LEDR[0]
    always @(negedge iCLK_50) begin
        if (arstN && ledr[0])
            tickCount <= tickCount + 1;
    end

    //////////////////////////////////////////////////
    // Bus and pin drivers
    //////////////////////////////////////////////////
    task automatic busWrite(input busAddr_t addr, input byteEn_t be, input busData_t data);
        @(posedge iCLK_50);
        writeEnable <= 1'b1;
        address     <= addr;
        byteEnable  <= be;
        writeData   <= data;
        @(posedge iCLK_50);
        writeEnable <= 1'b0;
    endtask

    task automatic busRead(input busAddr_t addr, output busData_t data);
        @(posedge iCLK_50);
        readEnable <= 1'b1;
        address    <= addr;
        @(posedge iCLK_50);
        readEnable <= 1'b0;
        @(negedge iCLK_50);
        data = readData;                    // Registered one cycle after the strobe
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge iCLK_50);
    endtask

    task automatic pressKey(input int idx);
        @(posedge iCLK_50);
        KEY <= ~(4'b0001 << idx);           // Active low
        repeat (6) @(posedge iCLK_50);
        KEY <= 4'hF;
        repeat (6) @(posedge iCLK_50);
    endtask

    task automatic waitLedr(input int idx, input logic value, input int limit, input string what);
        int n;
        n = 0;
        while (ledr[idx] !== value && n < limit) begin
            @(negedge iCLK_50);
            n++;
        end
        if (ledr[idx] !== value) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            errCount++;
        end
    endtask

    task automatic countTicks(input int n, output int ticks);
        int t0;
        @(posedge iCLK_50);
        t0 = tickCount;
        repeat (n) @(posedge iCLK_50);
        ticks = tickCount - t0;
    endtask

    function automatic busData_t nextLfsr(input busData_t v);
        return (v >> 1) ^ (v[0] ? busData_t'(`LFSR_TAPS) : busData_t'(0));
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks and test bookkeeping
    //////////////////////////////////////////////////
    task automatic checkData(input string name, input busData_t got, input busData_t exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkState(input string name, input logic expHalted, input clkMode_t expMode);
        logic     gotHalted;
        clkMode_t gotMode;
        @(negedge iCLK_50);
        gotHalted = ledr[2];
        gotMode   = clkMode_t'(ledr[1]);
        if (gotHalted !== expHalted) begin
            $display("FAILED %s halted got 0x%h expected 0x%h", name, gotHalted, expHalted);
            errCount++;
        end
        if (gotMode !== expMode) begin
            $display("FAILED %s mode got 0x%h expected 0x%h", name, gotMode, expMode);
            errCount++;
        end
    endtask

    task automatic checkTicks(input string name, input int got, input int exp, input int tol);
        if (got < exp - tol || got > exp + tol) begin
            $display("FAILED %s got 0x%h expected 0x%h within %0d", name, got, exp, tol);
            errCount++;
        end
    endtask

    task automatic beginTest();
        testErrBase = errCount;
    endtask

    task automatic finishTest(input string name);
        if (errCount == testErrBase) begin
            $display("%-28s ok", name);
            passTests++;
        end else begin
            $display("%-28s %0d errors", name, errCount - testErrBase);
            failTests++;
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task automatic runCaseFile();
        int       idx;
        logic     done;
        busData_t op;
        busAddr_t addr;
        busData_t data;
        busData_t expVal;
        busData_t got;
        idx  = 0;
        done = 1'b0;
        while (!done && idx < CASE_MAX) begin
            op     = caseWords[5*idx];
            addr   = caseWords[5*idx + 1];
            data   = caseWords[5*idx + 3];
            expVal = caseWords[5*idx + 4];
            if ($isunknown(op) || op == 0) begin
                done = 1'b1;
            end else begin
                case (op)
                    1: begin
                        busWrite(addr, byteEn_t'(caseWords[5*idx + 2]), data);
                        if (addr == `LFSR_ADDR)
                            lfsrModel = (data == 0) ? busData_t'(1) : data;
                    end
                    2: begin
                        if (addr == `LFSR_ADDR) begin
                            expVal    = lfsrModel;
                            lfsrModel = nextLfsr(lfsrModel);
                        end
                        busRead(addr, got);
                        checkData($sformatf("readData case %0d", idx), got, expVal);
                    end
                    3: idleCycles(int'(data));
                    default: begin
                        $display("Case %0d has an unknown operation code", idx);
                        errCount++;
                    end
                endcase
                idx++;
            end
        end
        if (idx == 0) begin
            $display("The case file held no bus operations");
            errCount++;
        end
    endtask

    task automatic testRandomMem();
        busData_t model [16];
        busData_t wd;
        busData_t got;
        byteEn_t  be;
        for (int i = 0; i < 16; i++) begin
            wd       = $random(seed);
            model[i] = wd;
            busWrite(`MEM_BASE + 32'h100 + 32'(4 * i), 4'hF, wd);
        end
        for (int i = 0; i < 16; i++) begin
            be = byteEn_t'($random(seed));
            wd = $random(seed);
            for (int b = 0; b < `BE_WIDTH; b++) begin
                if (be[b])
                    model[i][8*b +: 8] = wd[8*b +: 8];  // Merge enabled lanes
            end
            busWrite(`MEM_BASE + 32'h100 + 32'(4 * i), be, wd);
        end
        for (int i = 0; i < 16; i++) begin
            busRead(`MEM_BASE + 32'h100 + 32'(4 * i), got);
            checkData($sformatf("readData word %0d", 64 + i), got, model[i]);
        end
    endtask

    task automatic testStopwatch();
        busData_t first;
        busData_t second;
        busWrite(`SW_LO_ADDR, 4'hF, '0);
        idleCycles(520);
        busRead(`SW_LO_ADDR, first);
        checkTicks("swLo", int'(first), 520 / `US_PRESCALE, 1);
        idleCycles(300);
        busRead(`SW_LO_ADDR, second);
        checkTicks("swLo later", int'(second), (520 + 300) / `US_PRESCALE, 1);
        if (second < first) begin
            $display("Stopwatch count went backwards between two reads");
            errCount++;
        end
        busRead(`SW_HI_ADDR, second);
        checkData("swHi", second, '0);
    endtask

    task automatic testBreaks();
        int       ticks;
        busData_t got;
        // Break on address, divided mode still running
        busWrite(`BRK_ADDR_ADDR, 4'hF, 32'h0040_0040);
        busWrite(`BRK_CTRL_ADDR, 4'hF, 32'h1);
        @(posedge iCLK_50);
        pc <= 32'h0040_0040;
        waitLedr(2, 1'b1, 50, "halt on break address");
        countTicks(100, ticks);
        checkTicks("cpuTick halted", ticks, 0, 0);
        busRead(`BRK_CTRL_ADDR, got);
        checkData("brkStatus", got, 32'h3);
        busRead(`BRK_ADDR_ADDR, got);
        checkData("brkAddrData", got, 32'h0040_0040);
        busWrite(`BRK_CTRL_ADDR, 4'hF, 32'h0);
        @(posedge iCLK_50);
        pc <= '0;
        pressKey(1);
        waitLedr(2, 1'b0, 40, "resume after break address");
        checkState("resume", 1'b0, MODE_DIVIDED);
        // Break on ebreak in step mode
        pressKey(3);
        waitLedr(1, 1'b0, 40, "return to step mode");
        @(posedge iCLK_50);
        ebreak <= 1'b1;
        ticks = tickCount;
        pressKey(2);
        waitLedr(2, 1'b1, 40, "halt on ebreak");
        checkTicks("cpuTick step", tickCount - ticks, 1, 0);
        busRead(`BRK_CTRL_ADDR, got);
        checkData("brkStatus", got, 32'h5);
        checkState("ebreak halt", 1'b1, MODE_STEP);
        ticks = tickCount;
        pressKey(2);                        // Must be dropped while halted
        idleCycles(8);
        checkTicks("cpuTick step halted", tickCount - ticks, 0, 0);
        @(posedge iCLK_50);
        ebreak <= 1'b0;
        pressKey(1);
        waitLedr(2, 1'b0, 40, "resume after ebreak");
        checkState("resume", 1'b0, MODE_STEP);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int ticks;
        iCLK_50     = 1'b0;
        arstN       = 1'b0;
        KEY         = 4'hF;
        SW          = 5'd0;
        pc          = '0;
        ebreak      = 1'b0;
        readEnable  = 1'b0;
        writeEnable = 1'b0;
        byteEnable  = '0;
        address     = '0;
        writeData   = '0;
        lfsrModel   = busData_t'(1);
        seed        = 32'hd3b9;
        tickCount   = 0;
        errCount    = 0;
        passTests   = 0;
        failTests   = 0;
        $readmemh("test/busCases.txt", caseWords);

        repeat (8) @(posedge iCLK_50);
        arstN <= 1'b1;

        beginTest();
        checkState("reset", 1'b0, MODE_STEP);
        checkData("readData", readData, '0);
        checkData("ledr", busData_t'(ledr), '0);
        finishTest("Reset state");

        beginTest();
        runCaseFile();
        finishTest("Bus cases from file");

        beginTest();
        testRandomMem();
        finishTest("Random memory traffic");

        beginTest();
        testStopwatch();
        finishTest("Stopwatch");

        beginTest();
        @(posedge iCLK_50);
        SW <= 5'd4;
        pressKey(3);
        waitLedr(1, 1'b1, 40, "divided mode");
        countTicks(400, ticks);
        checkTicks("cpuTick divided", ticks, 100, 1);
        checkState("divided", 1'b0, MODE_DIVIDED);
        finishTest("Divided CPU tick");

        beginTest();
        testBreaks();
        finishTest("Break address and ebreak");

        $display("Tests passed: %0d, failed: %0d", passTests, failTests);
        if (failTests == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- src/socTop.sv
// SoC peripheral top level
// Connects the CPU clock controller, the data bus decoder and
// the memory, stopwatch, LFSR and break peripherals to the
// board keys, switches, LEDs and the external data bus.

`timescale 1ns/1ps
`include "periph_macros.svh"

module socTop
    import periphPkg::*;
(
    input  logic       iCLK_50,
    input  logic       arstN,
    input  logic [3:0] KEY,
    input  logic [4:0] SW,
    input  busAddr_t   pc,
    input  logic       ebreak,
    input  logic       readEnable,
    input  logic       writeEnable,
    input  byteEn_t    byteEnable,
    input  busAddr_t   address,
    input  busData_t   writeData,
    output busData_t   readData,
    output logic [2:0] ledr
);

    logic       cpuTick;
    clkMode_t   mode;
    logic       resumePress;
    logic       halted;

    logic [7:0] memIndex;
    logic       memWr;
    logic       swWr;
    logic       lfsrRd;
    logic       lfsrWr;
    logic       brkAddrWr;
    logic       brkCtrlWr;
    busData_t   memData;
    busData_t   swLo;
    busData_t   swHi;
    busData_t   lfsrData;
    busData_t   brkAddrData;
    busData_t   brkStatus;

    //////////////////////////////////////////////////
    // Clock control and bus decode
    //////////////////////////////////////////////////
    clockControl clockCtrl0 (
        .iCLK_50     (iCLK_50),
        .arstN       (arstN),
        .KEY         (KEY),
        .SW          (SW),              // fdiv
        .halted      (halted),
        .cpuTick     (cpuTick),
        .mode        (mode),
        .resumePress (resumePress)
    );

    periphBus bus0 (
        .iCLK_50     (iCLK_50),
        .arstN       (arstN),
        .readEnable  (readEnable),
        .writeEnable (writeEnable),
        .address     (address),
        .memIndex    (memIndex),
        .memRd       (),                // Memory reads are combinational
        .memWr       (memWr),
        .swRd        (),
        .swWr        (swWr),
        .lfsrRd      (lfsrRd),
        .lfsrWr      (lfsrWr),
        .brkAddrWr   (brkAddrWr),
        .brkCtrlWr   (brkCtrlWr),
        .memData     (memData),
        .swLo        (swLo),
        .swHi        (swHi),
        .lfsrData    (lfsrData),
        .brkAddrData (brkAddrData),
        .brkStatus   (brkStatus),
        .readData    (readData)
    );

    //////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////
    dataMemory memData0 (
        .iCLK_50    (iCLK_50),
        .memIndex   (memIndex),
        .memWr      (memWr),
        .byteEnable (byteEnable),
        .writeData  (writeData),
        .memData    (memData)
    );

    stopwatch stopwatch0 (
        .iCLK_50 (iCLK_50),
        .arstN   (arstN),
        .swWr    (swWr),
        .swLo    (swLo),
        .swHi    (swHi)
    );

    lfsrGen lfsr0 (
        .iCLK_50   (iCLK_50),
        .arstN     (arstN),
        .lfsrRd    (lfsrRd),
        .lfsrWr    (lfsrWr),
        .writeData (writeData),
        .lfsrData  (lfsrData)
    );

    breakUnit break0 (
        .iCLK_50     (iCLK_50),
        .arstN       (arstN),
        .cpuTick     (cpuTick),         // Gates pc sampling
        .pc          (pc),
        .ebreak      (ebreak),
        .resumePress (resumePress),
        .brkAddrWr   (brkAddrWr),
        .brkCtrlWr   (brkCtrlWr),
        .writeData   (writeData),
        .halted      (halted),
        .brkAddrData (brkAddrData),
        .brkStatus   (brkStatus)
    );

    // LEDR[2:0]
    assign ledr = {halted, mode == MODE_DIVIDED, cpuTick};

endmodule

//--- src/breakUnit.sv
// Break unit
// Watches the CPU program counter and the ebreak strobe on
// each cpuTick. A hit halts the CPU clock until the resume key.
// Holds the break address, an enable bit and a status word.

`timescale 1ns/1ps
`include "periph_macros.svh"

module breakUnit
    import periphPkg::*;
(
    input  logic     iCLK_50,
    input  logic     arstN,
    input  logic     cpuTick,
    input  busAddr_t pc,
    input  logic     ebreak,
    input  logic     resumePress,
    input  logic     brkAddrWr,
    input  logic     brkCtrlWr,
    input  busData_t writeData,
    output logic     halted,
    output busData_t brkAddrData,
    output busData_t brkStatus
);

    brkState_t state;
    busAddr_t  brkAddr;
    logic      brkEnable;
    logic      ebreakCause;         // Last halt came from ebreak

    //////////////////////////////////////////////////
    // Registers and halt FSM
    //////////////////////////////////////////////////
    always_ff @(posedge iCLK_50 or negedge arstN) begin
        if (!arstN) begin
            state       <= BRK_RUN;
            brkAddr     <= '0;
            brkEnable   <= 1'b0;
            ebreakCause <= 1'b0;
        end else begin
            if (brkAddrWr)
                brkAddr <= writeData;
            if (brkCtrlWr)
                brkEnable <= writeData[0];
            case (state)
                BRK_RUN: begin
                    if (cpuTick && ebreak) begin
                        state       <= BRK_HALT;
                        ebreakCause <= 1'b1;
                    end else if (cpuTick && brkEnable && pc == brkAddr) begin
                        state       <= BRK_HALT;
                        ebreakCause <= 1'b0;
                    end
                end
                BRK_HALT: if (resumePress) state <= BRK_RUN;
                default:  state <= BRK_RUN;
            endcase
        end
    end

    assign halted      = (state == BRK_HALT);
    assign brkAddrData = brkAddr;
    assign brkStatus   = {{(`BUS_WIDTH-3){1'b0}}, ebreakCause, brkEnable, halted};

endmodule

//--- src/lfsrGen.sv
// Random number generator
// 32-bit Galois LFSR. A bus write loads the seed, and every
// read steps the register once after returning its value.

`timescale 1ns/1ps
`include "periph_macros.svh"

module lfsrGen
    import periphPkg::*;
(
    input  logic     iCLK_50,
    input  logic     arstN,
    input  logic     lfsrRd,
    input  logic     lfsrWr,
    input  busData_t writeData,
    output busData_t lfsrData
);

    busData_t lfsr;
    busData_t lfsrNext;

    // Shift right and fold the taps back when a one drops out
    assign lfsrNext = (lfsr >> 1) ^ (lfsr[0] ? busData_t'(`LFSR_TAPS) : '0);

    always_ff @(posedge iCLK_50 or negedge arstN) begin
        if (!arstN)
            lfsr <= busData_t'(1);
        else if (lfsrWr)
            lfsr <= (writeData == '0) ? busData_t'(1) : writeData;   // Zero would lock up
        else if (lfsrRd)
            lfsr <= lfsrNext;
    end

    assign lfsrData = lfsr;

    // Seeds and steps both keep the state out of zero
    assert property (@(posedge iCLK_50) disable iff (!arstN) lfsr != '0)
        else $error("LFSR reached the all-zero state");

endmodule

//--- src/stopwatch.sv
// Stopwatch
// Free running microsecond counter, 64 bits wide, read as a
// low and a high word. A write to either word restarts it.

`timescale 1ns/1ps
`include "periph_macros.svh"

module stopwatch
    import periphPkg::*;
(
    input  logic     iCLK_50,
    input  logic     arstN,
    input  logic     swWr,
    output busData_t swLo,
    output busData_t swHi
);

    localparam int PRE_W = $clog2(`US_PRESCALE);

    logic [PRE_W-1:0]        preCnt;
    logic                    preDone;
    logic [2*`BUS_WIDTH-1:0] usCount;

    assign preDone = (preCnt == PRE_W'(`US_PRESCALE - 1));

    //////////////////////////////////////////////////
    // Prescaler and microsecond count
    //////////////////////////////////////////////////
    always_ff @(posedge iCLK_50 or negedge arstN) begin
        if (!arstN) begin
            preCnt  <= '0;
            usCount <= '0;
        end else if (swWr) begin
            // Restart mid-microsecond too
            preCnt  <= '0;
            usCount <= '0;
        end else if (preDone) begin
            preCnt  <= '0;
            usCount <= usCount + 1'b1;
        end else begin
            preCnt  <= preCnt + 1'b1;
        end
    end

    assign swLo = usCount[`BUS_WIDTH-1:0];
    assign swHi = usCount[2*`BUS_WIDTH-1:`BUS_WIDTH];

endmodule

//--- src/dataMemory.sv
// Data memory
// Word-wide RAM on the shared data bus. Each byte lane is
// written only when its byte enable is set. The read word
// follows the index directly and the bus decoder registers it.

`timescale 1ns/1ps
`include "periph_macros.svh"

module dataMemory
    import periphPkg::*;
(
    input  logic       iCLK_50,
    input  logic [7:0] memIndex,
    input  logic       memWr,
    input  byteEn_t    byteEnable,
    input  busData_t   writeData,
    output busData_t   memData
);

    busData_t mem [`MEM_WORDS];

    //////////////////////////////////////////////////
    // Byte lane writes
    //////////////////////////////////////////////////
    always_ff @(posedge iCLK_50) begin
        if (memWr) begin
            for (int b = 0; b < `BE_WIDTH; b++) begin
                if (byteEnable[b])
                    mem[memIndex][8*b +: 8] <= writeData[8*b +: 8];
            end
        end
    end

    // Asynchronous read port
    assign memData = mem[memIndex];

endmodule

//--- src/periphBus.sv
// Peripheral bus decoder
// Maps the data bus address to one target, fans out the read
// and write strobes and registers the selected read word

`timescale 1ns/1ps
`include "periph_macros.svh"

module periphBus
    import periphPkg::*;
(
    input  logic       iCLK_50,
    input  logic       arstN,
    input  logic       readEnable,
    input  logic       writeEnable,
    input  busAddr_t   address,
    output logic [7:0] memIndex,
    output logic       memRd,
    output logic       memWr,
    output logic       swRd,
    output logic       swWr,
    output logic       lfsrRd,
    output logic       lfsrWr,
    output logic       brkAddrWr,
    output logic       brkCtrlWr,
    input  busData_t   memData,
    input  busData_t   swLo,
    input  busData_t   swHi,
    input  busData_t   lfsrData,
    input  busData_t   brkAddrData,
    input  busData_t   brkStatus,
    output busData_t   readData
);

    periphSel_t sel;
    busAddr_t   memOffset;
    logic       isSw;
    logic       isBrk;
    logic       brkRd;
    busData_t   rdWord;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    assign memOffset = address - `MEM_BASE;
    assign memIndex  = memOffset[9:2];          // Word index

    always_comb begin
        sel = SEL_NONE;
        if (memOffset < busAddr_t'(`MEM_WORDS * 4))
            sel = SEL_MEM;
        else begin
            case (address)
                `SW_LO_ADDR:    sel = SEL_SW_LO;
                `SW_HI_ADDR:    sel = SEL_SW_HI;
                `LFSR_ADDR:     sel = SEL_LFSR;
                `BRK_ADDR_ADDR: sel = SEL_BRK_ADDR;
                `BRK_CTRL_ADDR: sel = SEL_BRK_CTRL;
                default:        sel = SEL_NONE;
            endcase
        end
    end

    assign isSw  = (sel == SEL_SW_LO) || (sel == SEL_SW_HI);
    assign isBrk = (sel == SEL_BRK_ADDR) || (sel == SEL_BRK_CTRL);

    assign memRd     = readEnable  && (sel == SEL_MEM);
    assign memWr     = writeEnable && (sel == SEL_MEM);
    assign swRd      = readEnable  && isSw;
    assign swWr      = writeEnable && isSw;     // Either word clears
    assign lfsrRd    = readEnable  && (sel == SEL_LFSR);
    assign lfsrWr    = writeEnable && (sel == SEL_LFSR);
    assign brkRd     = readEnable  && isBrk;
    assign brkAddrWr = writeEnable && (sel == SEL_BRK_ADDR);
    assign brkCtrlWr = writeEnable && (sel == SEL_BRK_CTRL);

    //////////////////////////////////////////////////
    // Read mux, one cycle latency
    //////////////////////////////////////////////////
    always_comb begin
        rdWord = '0;                            // Unmapped reads give 0
        if (memRd)
            rdWord = memData;
        if (swRd)
            rdWord = (sel == SEL_SW_HI) ? swHi : swLo;
        if (lfsrRd)
            rdWord = lfsrData;
        if (brkRd)
            rdWord = (sel == SEL_BRK_CTRL) ? brkStatus : brkAddrData;
    end

    always_ff @(posedge iCLK_50 or negedge arstN) begin
        if (!arstN)
            readData <= '0;
        else if (readEnable)
            readData <= rdWord;                 // Held until next read
    end

    assert property (@(posedge iCLK_50) disable iff (!arstN) !(readEnable && writeEnable))
        else $error("Read and write strobes in the same cycle");

endmodule

//--- src/clockControl.sv
// CPU clock controller
// Synchronizes the board keys and turns them into press pulses.
// Produces the cpuTick enable from single step or from the SW
// divider, and holds it off while the break unit is halted.

`timescale 1ns/1ps
`include "periph_macros.svh"

module clockControl
    import periphPkg::*;
(
    input  logic       iCLK_50,
    input  logic       arstN,
    input  logic [3:0] KEY,         // Active low
    input  logic [4:0] SW,          // fdiv
    input  logic       halted,
    output logic       cpuTick,
    output clkMode_t   mode,
    output logic       resumePress
);

    logic [3:0] keySync1;
    logic [3:0] keySync2;
    logic [3:0] keyPrev;
    logic [3:0] keyPress;           // One cycle per press
    logic       stepPulse;
    logic [4:0] divCnt;
    logic [4:0] fdivEff;
    logic       divHit;

    //////////////////////////////////////////////////
    // Key synchronizer and press detect
    //////////////////////////////////////////////////
    always_ff @(posedge iCLK_50 or negedge arstN) begin
        if (!arstN) begin
            keySync1 <= '1;
            keySync2 <= '1;
            keyPrev  <= '1;
            keyPress <= '0;
        end else begin
            keySync1 <= KEY;
            keySync2 <= keySync1;
            keyPrev  <= keySync2;
            keyPress <= keyPrev & ~keySync2;   // High to low
        end
    end

    //////////////////////////////////////////////////
    // Mode, step and divider
    //////////////////////////////////////////////////
    assign fdivEff = (SW == 5'd0) ? 5'd1 : SW;
    assign divHit  = (mode == MODE_DIVIDED) && (divCnt >= fdivEff - 5'd1);

    always_ff @(posedge iCLK_50 or negedge arstN) begin
        if (!arstN) begin
            mode      <= MODE_STEP;
            stepPulse <= 1'b0;
            divCnt    <= '0;
        end else begin
            if (keyPress[3])
                mode <= (mode == MODE_STEP) ? MODE_DIVIDED : MODE_STEP;
            // Presses while halted are dropped here
            stepPulse <= keyPress[2] && !halted && (mode == MODE_STEP);
            // KEY[0] realigns the divider phase
            if (mode != MODE_DIVIDED || keyPress[0])
                divCnt <= '0;
            else if (!halted)
                divCnt <= divHit ? 5'd0 : divCnt + 5'd1;   // Frozen while halted
        end
    end

    assign cpuTick     = stepPulse | (divHit & ~halted);
    assign resumePress = keyPress[1];

    // Halt must block both tick sources
    assert property (@(posedge iCLK_50) disable iff (!arstN) !(cpuTick && halted))
        else $error("cpuTick while halted");

endmodule

//--- src/periphPkg.sv
// Peripheral bus types
// Word, address and byte-enable vectors plus the state
// and target encodings shared by the peripheral blocks

`include "periph_macros.svh"

package periphPkg;

    typedef logic [`BUS_WIDTH-1:0] busAddr_t;
    typedef logic [`BUS_WIDTH-1:0] busData_t;
    typedef logic [`BE_WIDTH-1:0]  byteEn_t;

    // CPU clock source
    typedef enum logic {
        MODE_STEP,              // One tick per KEY[2] press
        MODE_DIVIDED            // Free running from SW
    } clkMode_t;

    typedef enum logic {
        BRK_RUN,
        BRK_HALT
    } brkState_t;

    // Decoder target
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_MEM,
        SEL_SW_LO,
        SEL_SW_HI,
        SEL_LFSR,
        SEL_BRK_ADDR,
        SEL_BRK_CTRL
    } periphSel_t;

endpackage

//--- src/periph_macros.svh
// Peripheral bus constants
// Bus widths, the data bus address map, the stopwatch
// prescale and the LFSR feedback mask

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////
`define BUS_WIDTH       32
`define BE_WIDTH        4               // One enable per byte lane

//////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////
`define MEM_BASE        32'h1001_0000   // Data segment
`define MEM_WORDS       256

`define SW_LO_ADDR      32'hFF20_0510   // Stopwatch low word
`define SW_HI_ADDR      32'hFF20_0514   // Stopwatch high word
`define LFSR_ADDR       32'hFF20_0518

`define BRK_ADDR_ADDR   32'hFF20_0600   // Break address
`define BRK_CTRL_ADDR   32'hFF20_0604   // Enable on write, status on read

//////////////////////////////////////////////////
// Timing and generators
//////////////////////////////////////////////////
`define US_PRESCALE     50              // 50 MHz cycles per microsecond

// Galois mask for a right-shifting register
`define LFSR_TAPS       32'h8020_0003

`endif
